/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cr_subsystem_tb
FILELIST = filelist.f
OBJ_DIR = obj_dir
LOG = run.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/cr_monitor.sv */
`timescale 1ns/1ns

module cr_monitor
	#(
	parameter MASK_WIDTH = 16
	)
	(
	input logic clk,
	input logic reset,
	// Expected values, valid from the falling edge the vector is driven on
	input logic exp_active,
	input logic exp_read,
	input logic [31:0] exp_data,
	input logic [MASK_WIDTH-1:0] exp_mask,
	input logic exp_bad,
	// DUT outputs
	input logic read_valid,
	input logic [31:0] read_data,
	input logic bad_core,
	input logic [MASK_WIDTH-1:0] strand_enable,
	input logic all_halted,
	input int assert_failures,
	input logic report,
	output int error_count
	);

	// Stage 1 lines up with bad_core, stage 2 with read data and masks
	logic s1_active;
	logic s1_read;
	logic [31:0] s1_data;
	logic [MASK_WIDTH-1:0] s1_mask;
	logic s1_bad;
	logic s2_active;
	logic s2_read;
	logic [31:0] s2_data;
	logic [MASK_WIDTH-1:0] s2_mask;
	int errors = 0;
	int checks = 0;

	assign error_count = errors;

	// Same edges as the DUT registers
	always @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s1_active <= 1'b0;
			s1_read <= 1'b0;
			s1_data <= '0;
			s1_mask <= '0;
			s1_bad <= 1'b0;
			s2_active <= 1'b0;
			s2_read <= 1'b0;
			s2_data <= '0;
			s2_mask <= '0;
		end
		else
		begin
			s1_active <= exp_active;
			s1_read <= exp_read;
			s1_data <= exp_data;
			s1_mask <= exp_mask;
			s1_bad <= exp_bad;
			s2_active <= s1_active;
			s2_read <= s1_read;
			s2_data <= s1_data;
			s2_mask <= s1_mask;
		end
	end

	// Outputs are stable mid cycle
	always @(negedge clk)
	begin
		if (!reset && s1_active)
		begin
			checks++;
			if (bad_core !== s1_bad)
			begin
				$display("FAIL bad_core: got %h, expected %h", bad_core, s1_bad);
				errors++;
			end
		end
		if (!reset && s2_active)
		begin
			checks++;
			if (s2_read && read_valid !== 1'b1)
			begin
				$display("Missing read_valid two cycles after a read request");
				errors++;
			end
			else if (!s2_read && read_valid !== 1'b0)
			begin
				$display("read_valid came without a read request");
				errors++;
			end
			else if (s2_read && read_data !== s2_data)
			begin
				$display("FAIL read_data: got %h, expected %h", read_data, s2_data);
				errors++;
			end
			if (strand_enable !== s2_mask)
			begin
				$display("FAIL strand_enable: got %h, expected %h", strand_enable, s2_mask);
				errors++;
			end
			// Halted exactly when no strand of any core runs
			if (all_halted !== (s2_mask == '0))
			begin
				$display("FAIL all_halted: got %h, expected %h", all_halted, s2_mask == '0);
				errors++;
			end
		end
	end

	always @(posedge report)
		$display("Checks: %0d, compare errors: %0d, assertion failures: %0d",
			checks, errors, assert_failures);

endmodule

/* bench/cr_subsystem_chk.sv */
`timescale 1ns/1ns

module cr_subsystem_chk
	import cr_bus_pkg::*;
	#(
	parameter NUM_CORES = 4,
	parameter STRANDS_PER_CORE = 4
	)
	(
	input logic clk,
	input logic reset,
	input cr_request_t request,
	input cr_fault_t fault,
	input logic read_valid,
	input logic bad_core,
	input logic [NUM_CORES*STRANDS_PER_CORE-1:0] strand_enable,
	input logic all_halted
	);

	int failures = 0;
	logic core_missing;

	// Access or fault aimed past the last core
	assign core_missing = (request.op != CR_OP_NONE && int'(request.core) >= NUM_CORES)
		|| (fault.valid && int'(fault.core) >= NUM_CORES);

	// Read returns two edges after sampling and only then
	read_latency: assert property (@(posedge clk) disable iff (reset)
		read_valid == $past(request.op == CR_OP_READ, 2))
		else
		begin
			$error("read_valid does not trail a read by two edges");
			failures++;
		end

	bad_core_pulse: assert property (@(posedge clk) disable iff (reset)
		bad_core == $past(core_missing))
		else
		begin
			$error("bad_core does not trail an out of range core by one edge");
			failures++;
		end

	// Masks and all_halted move only two edges after a write
	mask_update: assert property (@(posedge clk) disable iff (reset)
		(strand_enable != $past(strand_enable) || all_halted != $past(all_halted))
		|-> $past(request.op == CR_OP_WRITE, 2))
		else
		begin
			$error("enable masks or all_halted changed without a write two edges before");
			failures++;
		end

endmodule

bind cr_subsystem cr_subsystem_chk #(
	.NUM_CORES(NUM_CORES),
	.STRANDS_PER_CORE(STRANDS_PER_CORE)
) chk_i (
	.clk(clk),
	.reset(reset),
	.request(request),
	.fault(fault),
	.read_valid(read_valid),
	.bad_core(bad_core),
	.strand_enable(strand_enable),
	.all_halted(all_halted)
);

/* bench/cr_subsystem_tb.sv */
`timescale 1ns/1ns

module cr_subsystem_tb
	import cr_map_pkg::*;
	import cr_bus_pkg::*;
	();

	localparam int NUM_CORES = 4;
	localparam int STRANDS_PER_CORE = 4;
	localparam int MASK_WIDTH = NUM_CORES * STRANDS_PER_CORE;
	localparam int CLOCK_PERIOD = 100;
	localparam int VECTOR_COUNT = 25;
	// Columns of one vector in the data file
	localparam int WORDS_PER_VECTOR = 13;
	localparam logic [31:0] LCG_SEED = 32'h8100e20b;

	logic clk = 1'b0;
	logic reset;
	cr_request_t request;
	cr_fault_t fault;
	logic read_valid;
	logic [CR_DATA_WIDTH-1:0] read_data;
	logic bad_core;
	logic [NUM_CORES-1:0][STRANDS_PER_CORE-1:0] strand_enable;
	logic all_halted;

	// Expected values, handed to the monitor when the vector is driven
	logic exp_active;
	logic exp_read;
	logic [31:0] exp_data;
	logic [MASK_WIDTH-1:0] exp_mask;
	logic exp_bad;
	logic report;
	int error_count;
	int assert_failures;

	logic [31:0] vectors [VECTOR_COUNT * WORDS_PER_VECTOR];
	logic [31:0] lcg_state;
	int gap;

	always #(CLOCK_PERIOD / 2) clk = ~clk;

	cr_subsystem #(
		.NUM_CORES(NUM_CORES),
		.STRANDS_PER_CORE(STRANDS_PER_CORE)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.request(request),
		.fault(fault),
		.read_valid(read_valid),
		.read_data(read_data),
		.bad_core(bad_core),
		.strand_enable(strand_enable),
		.all_halted(all_halted)
	);

	// Failures seen by the bound assertion module
	assign assert_failures = dut_i.chk_i.failures;

	cr_monitor #(
		.MASK_WIDTH(MASK_WIDTH)
	) monitor_i (
		.clk(clk),
		.reset(reset),
		.exp_active(exp_active),
		.exp_read(exp_read),
		.exp_data(exp_data),
		.exp_mask(exp_mask),
		.exp_bad(exp_bad),
		.read_valid(read_valid),
		.read_data(read_data),
		.bad_core(bad_core),
		.strand_enable(strand_enable),
		.all_halted(all_halted),
		.assert_failures(assert_failures),
		.report(report),
		.error_count(error_count)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Quiet inputs, the expected mask holds the last state
	task automatic drive_idle();
		request = '0;
		fault = '0;
		exp_read = 1'b0;
		exp_data = '0;
		exp_bad = 1'b0;
	endtask

	// Unpack one line of the data file onto the DUT inputs
	task automatic drive_vector(input int v);
		int base;
		base = v * WORDS_PER_VECTOR;
		request.op = cr_op_e'(vectors[base][1:0]);
		request.core = vectors[base + 1][7:0];
		request.strand = vectors[base + 2][7:0];
		request.index = cr_index_e'(vectors[base + 3][4:0]);
		request.write_value = vectors[base + 4];
		fault.valid = vectors[base + 5][0];
		fault.core = vectors[base + 6][7:0];
		fault.strand = vectors[base + 7][7:0];
		fault.pc = vectors[base + 8];
		exp_read = request.op == CR_OP_READ;
		exp_data = vectors[base + 9];
		exp_mask = vectors[base + 10][MASK_WIDTH-1:0];
		exp_bad = vectors[base + 11][0];
		exp_active = 1'b1;
	endtask

	initial
	begin
		reset = 1'b1;
		report = 1'b0;
		exp_active = 1'b0;
		exp_mask = '0;
		lcg_state = LCG_SEED;
		drive_idle();
		$readmemh("bench/cr_testdata.hex", vectors);

		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int v = 0; v < VECTOR_COUNT; v++)
		begin
			drive_vector(v);
			@(negedge clk);
			lcg_state = lcg_next(lcg_state);
			// Chained vectors follow without a gap
			gap = vectors[v * WORDS_PER_VECTOR + 12][0] ? 0 : int'(lcg_state[31:30]);
			repeat (gap)
			begin
				drive_idle();
				@(negedge clk);
			end
		end

		// Let the last accesses drain through the pipeline
		drive_idle();
		repeat (3) @(negedge clk);
		#(CLOCK_PERIOD / 4);
		report = 1'b1;
		#(CLOCK_PERIOD / 4);
		if (error_count == 0 && assert_failures == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Worst case is three idle cycles per vector plus reset and drain
	initial
	begin
		#(CLOCK_PERIOD * (VECTOR_COUNT * 5 + 20));
		$display("Timeout: the test did not finish within the cycle limit");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* bench/cr_testdata.hex */
// op core strand index write_value  fault: valid core strand pc
// expected: read_data enable_mask(core3..core0) bad_core, then chain (1 = next vector without gap)
1 00 00 01 00000000 0 00 00 00000000 00000000 1111 0 0
1 00 03 00 00000000 0 00 00 00000000 00000003 1111 0 0
1 01 02 00 00000000 0 00 00 00000000 00000006 1111 0 0
1 02 01 00 00000000 0 00 00 00000000 00000009 1111 0 0
1 03 00 00 00000000 0 00 00 00000000 0000000c 1111 0 0
2 01 00 01 00002000 0 00 00 00000000 00000000 1111 0 1
1 01 00 01 00000000 0 00 00 00000000 00002000 1111 0 0
1 00 00 01 00000000 0 00 00 00000000 00000000 1111 0 0
2 02 00 1e 0000000b 0 00 00 00000000 00000000 1b11 0 1
1 02 03 1e 00000000 0 00 00 00000000 0000000b 1b11 0 0
0 00 00 00 00000000 1 01 02 00001234 00000000 1b11 0 0
2 03 00 01 00004000 1 01 03 00005678 00000000 1b11 0 1
0 00 00 00 00000000 1 01 02 0000abcd 00000000 1b11 0 1
1 01 02 02 00000000 0 00 00 00000000 0000abcd 1b11 0 0
1 01 03 02 00000000 0 00 00 00000000 00005678 1b11 0 0
1 03 02 01 00000000 0 00 00 00000000 00004000 1b11 0 0
2 02 01 1d 00000000 0 00 00 00000000 00000000 1911 0 0
2 00 00 1f 00000000 0 00 00 00000000 00000000 1910 0 0
2 01 00 1f 00000000 0 00 00 00000000 00000000 1900 0 0
2 02 00 1f 00000000 0 00 00 00000000 00000000 1000 0 0
2 03 00 1f 00000000 0 00 00 00000000 00000000 0000 0 0
1 04 00 01 00000000 0 00 00 00000000 00000000 0000 1 0
2 06 00 1e 0000000f 1 07 00 11111111 00000000 0000 1 0
2 00 00 1e 00000005 0 00 00 00000000 00000000 0005 0 1
1 00 02 1e 00000000 0 00 00 00000000 00000005 0005 0 0

/* filelist.f */
src/cr_map_pkg.sv
src/cr_bus_pkg.sv
src/cr_request_router.sv
src/control_registers.sv
src/cr_response_collector.sv
src/cr_subsystem.sv
bench/cr_subsystem_chk.sv
bench/cr_monitor.sv
bench/cr_subsystem_tb.sv

/* src/control_registers.sv */
`timescale 1ns/1ns

module control_registers
	import cr_map_pkg::*;
	import cr_bus_pkg::*;
	#(
	parameter CORE_ID = 0,
	parameter STRANDS_PER_CORE = 4
	)
	(
	input logic clk,
	input logic reset,
	// Registered access, qualified by select
	input cr_request_t access,
	input logic select,
	// Registered fault, qualified by fault_select
	input cr_fault_t fault,
	input logic fault_select,
	output logic [STRANDS_PER_CORE-1:0] strand_enable,
	output logic [CR_DATA_WIDTH-1:0] read_value
	);

	localparam int STRAND_INDEX_WIDTH = STRANDS_PER_CORE > 1 ? $clog2(STRANDS_PER_CORE) : 1;

	logic [CR_DATA_WIDTH-1:0] exception_handler;
	logic [CR_DATA_WIDTH-1:0] saved_fault_pc [STRANDS_PER_CORE];

	logic [STRAND_INDEX_WIDTH-1:0] strand_index;
	logic [STRAND_INDEX_WIDTH-1:0] fault_strand;
	logic strand_valid;
	logic fault_strand_valid;
	logic [CR_DATA_WIDTH-1:0] strand_fault_pc;
	logic [CR_DATA_WIDTH-1:0] strand_id;
	logic write_en;

	assign strand_index = access.strand[STRAND_INDEX_WIDTH-1:0];
	assign fault_strand = fault.strand[STRAND_INDEX_WIDTH-1:0];

	// Guard for strand counts that are not a power of two
	assign strand_valid = int'(strand_index) < STRANDS_PER_CORE;
	assign fault_strand_valid = int'(fault_strand) < STRANDS_PER_CORE;

	// Saved PC of the strand doing the access
	assign strand_fault_pc = strand_valid ? saved_fault_pc[strand_index] : '0;

	// Core number sits directly above the strand index
	assign strand_id = (CR_DATA_WIDTH'(CORE_ID) << STRAND_INDEX_WIDTH)
		| CR_DATA_WIDTH'(strand_index);

	assign write_en = select && access.op == CR_OP_WRITE;

	// Read mux, the collector picks which bank counts
	always_comb
	begin
		case (access.index)
			CR_STRAND_ID:
				read_value = strand_id;
			CR_EXCEPTION_HANDLER:
				read_value = exception_handler;
			CR_FAULT_ADDRESS:
				read_value = strand_fault_pc;
			CR_STRAND_ENABLE:
				read_value = CR_DATA_WIDTH'(strand_enable);
			default:
				read_value = '0;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			strand_enable <= CR_STRAND_ENABLE_RESET[STRANDS_PER_CORE-1:0];
			exception_handler <= CR_HANDLER_RESET;
			for (int i = 0; i < STRANDS_PER_CORE; i++)
				saved_fault_pc[i] <= CR_FAULT_PC_RESET;
		end
		else
		begin
			// Register writes, unknown indices fall through untouched
			if (write_en)
			begin
				case (access.index)
					CR_HALT_STRAND:
						strand_enable <= strand_enable
							& ~(STRANDS_PER_CORE'(1) << strand_index);
					CR_EXCEPTION_HANDLER:
						exception_handler <= access.write_value;
					CR_STRAND_ENABLE:
						strand_enable <= access.write_value[STRANDS_PER_CORE-1:0];
					CR_HALT:
						strand_enable <= '0;
					default:
						;
				endcase
			end

			// Latch the faulting PC, independent of any write this cycle
			if (fault_select && fault.valid && fault_strand_valid)
				saved_fault_pc[fault_strand] <= fault.pc;
		end
	end

endmodule

/* src/cr_bus_pkg.sv */
package cr_bus_pkg;

	import cr_map_pkg::*;

	// Field widths of core and strand numbers on the bus
	localparam int CR_CORE_WIDTH = 8;
	localparam int CR_STRAND_WIDTH = 8;

	// Access opcode
	// One opcode per request, so read and write never overlap
	typedef enum logic [1:0]
	{
		CR_OP_NONE = 2'd0,
		CR_OP_READ = 2'd1,
		CR_OP_WRITE = 2'd2
	} cr_op_e;

	// Register access from the host side, 55 bits
	typedef struct packed
	{
		cr_op_e op;
		logic [CR_CORE_WIDTH-1:0] core;
		logic [CR_STRAND_WIDTH-1:0] strand;
		cr_index_e index;
		logic [CR_DATA_WIDTH-1:0] write_value;
	} cr_request_t;

	// Fault report from writeback, 49 bits
	typedef struct packed
	{
		logic valid;
		logic [CR_CORE_WIDTH-1:0] core;
		logic [CR_STRAND_WIDTH-1:0] strand;
		logic [CR_DATA_WIDTH-1:0] pc;
	} cr_fault_t;

endpackage

/* src/cr_map_pkg.sv */
package cr_map_pkg;

	// Index field width, as carried in an access
	localparam int CR_INDEX_WIDTH = 5;

	// Width of every register value and saved PC
	localparam int CR_DATA_WIDTH = 32;

	// Control register indices
	// Indices not listed here read as zero and ignore writes
	typedef enum logic [CR_INDEX_WIDTH-1:0]
	{
		CR_STRAND_ID = 5'd0,
		CR_EXCEPTION_HANDLER = 5'd1,
		CR_FAULT_ADDRESS = 5'd2,
		CR_HALT_STRAND = 5'd29,
		CR_STRAND_ENABLE = 5'd30,
		CR_HALT = 5'd31
	} cr_index_e;

	// Enable mask after reset
	// Only strand 0 runs, the others wait to be started
	localparam logic [CR_DATA_WIDTH-1:0] CR_STRAND_ENABLE_RESET = 32'h0000_0001;

	// Handler address after reset
	localparam logic [CR_DATA_WIDTH-1:0] CR_HANDLER_RESET = '0;

	// Saved fault PC after reset
	localparam logic [CR_DATA_WIDTH-1:0] CR_FAULT_PC_RESET = '0;

endpackage

/* src/cr_request_router.sv */
`timescale 1ns/1ns

module cr_request_router
	import cr_bus_pkg::*;
	#(
	parameter NUM_CORES = 4,
	parameter STRANDS_PER_CORE = 4
	)
	(
	input logic clk,
	input logic reset,
	input cr_request_t request,
	input cr_fault_t fault,
	output cr_request_t access,
	output logic [NUM_CORES-1:0] select,
	output cr_fault_t fault_q,
	output logic [NUM_CORES-1:0] fault_select,
	output logic read_pending,
	output logic [NUM_CORES-1:0] read_select,
	output logic bad_core
	);

	// At least one bit even for a single strand
	localparam int STRAND_INDEX_WIDTH = STRANDS_PER_CORE > 1 ? $clog2(STRANDS_PER_CORE) : 1;

	cr_request_t request_clean;
	cr_fault_t fault_clean;
	logic request_active;
	logic [NUM_CORES-1:0] request_decode;
	logic [NUM_CORES-1:0] fault_decode;

	assign request_active = request.op != CR_OP_NONE;

	// One-hot core decode
	// Out of range core numbers match no bit and leave the vector empty
	always_comb
	begin
		for (int i = 0; i < NUM_CORES; i++)
		begin
			request_decode[i] = request_active && int'(request.core) == i;
			fault_decode[i] = fault.valid && int'(fault.core) == i;
		end
	end

	// Strand numbers trimmed to the bits a bank actually decodes
	always_comb
	begin
		request_clean = request;
		request_clean.strand = CR_STRAND_WIDTH'(request.strand[STRAND_INDEX_WIDTH-1:0]);
		fault_clean = fault;
		fault_clean.strand = CR_STRAND_WIDTH'(fault.strand[STRAND_INDEX_WIDTH-1:0]);
		// Drop a fault that has no target core
		fault_clean.valid = fault.valid && |fault_decode;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			access <= '0;
			select <= '0;
			fault_q <= '0;
			fault_select <= '0;
			read_pending <= 1'b0;
			read_select <= '0;
			bad_core <= 1'b0;
		end
		else
		begin
			access <= request_clean;
			select <= request_decode;
			fault_q <= fault_clean;
			fault_select <= fault_decode;
			// A read to a missing core still returns, with zero data
			read_pending <= request.op == CR_OP_READ;
			read_select <= request.op == CR_OP_READ ? request_decode : '0;
			// Any access or fault whose core matched nothing
			bad_core <= (request_active && !(|request_decode))
				|| (fault.valid && !(|fault_decode));
		end
	end

endmodule

/* src/cr_response_collector.sv */
`timescale 1ns/1ns

module cr_response_collector
	import cr_map_pkg::*;
	#(
	parameter NUM_CORES = 4,
	parameter STRANDS_PER_CORE = 4
	)
	(
	input logic clk,
	input logic reset,
	// From the router, one cycle after the request
	input logic read_pending,
	input logic [NUM_CORES-1:0] read_select,
	// One word and one mask per bank
	input logic [NUM_CORES-1:0][CR_DATA_WIDTH-1:0] read_values,
	input logic [NUM_CORES-1:0][STRANDS_PER_CORE-1:0] core_enables,
	output logic read_valid,
	output logic [CR_DATA_WIDTH-1:0] read_data,
	output logic [NUM_CORES-1:0][STRANDS_PER_CORE-1:0] strand_enable,
	output logic all_halted
	);

	logic [CR_DATA_WIDTH-1:0] read_merge;

	// AND-OR mux over the banks
	// Empty select, as for a bad core, gives zero
	always_comb
	begin
		read_merge = '0;
		for (int i = 0; i < NUM_CORES; i++)
		begin
			if (read_select[i])
				read_merge = read_merge | read_values[i];
		end
	end

	// Return strobe, one cycle per read
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			read_valid <= 1'b0;
		else
			read_valid <= read_pending;
	end

	// Read data, held between reads
	always_ff @(posedge clk)
	begin
		if (read_pending)
			read_data <= read_merge;
	end

	// Masks of all banks side by side
	assign strand_enable = core_enables;

	// Halted means no strand is enabled on any core
	assign all_halted = ~|core_enables;

endmodule

/* src/cr_subsystem.sv */
`timescale 1ns/1ns

module cr_subsystem
	import cr_map_pkg::*;
	import cr_bus_pkg::*;
	#(
	parameter NUM_CORES = 4,
	parameter STRANDS_PER_CORE = 4
	)
	(
	input logic clk,
	input logic reset,
	input cr_request_t request,
	input cr_fault_t fault,
	output logic read_valid,
	output logic [CR_DATA_WIDTH-1:0] read_data,
	output logic bad_core,
	output logic [NUM_CORES-1:0][STRANDS_PER_CORE-1:0] strand_enable,
	output logic all_halted
	);

	// Router to banks
	cr_request_t access;
	logic [NUM_CORES-1:0] select;
	cr_fault_t fault_q;
	logic [NUM_CORES-1:0] fault_select;

	// Router to collector
	logic read_pending;
	logic [NUM_CORES-1:0] read_select;

	// Banks to collector
	logic [NUM_CORES-1:0][CR_DATA_WIDTH-1:0] read_values;
	logic [NUM_CORES-1:0][STRANDS_PER_CORE-1:0] core_enables;

	cr_request_router #(
		.NUM_CORES(NUM_CORES),
		.STRANDS_PER_CORE(STRANDS_PER_CORE)
	) router_i (
		.clk(clk),
		.reset(reset),
		.request(request),
		.fault(fault),
		.access(access),
		.select(select),
		.fault_q(fault_q),
		.fault_select(fault_select),
		.read_pending(read_pending),
		.read_select(read_select),
		.bad_core(bad_core)
	);

	// One bank per core, numbered by the loop index
	for (genvar i = 0; i < NUM_CORES; i++)
	begin : gen_core
		control_registers #(
			.CORE_ID(i),
			.STRANDS_PER_CORE(STRANDS_PER_CORE)
		) bank_i (
			.clk(clk),
			.reset(reset),
			.access(access),
			.select(select[i]),
			.fault(fault_q),
			.fault_select(fault_select[i]),
			.strand_enable(core_enables[i]),
			.read_value(read_values[i])
		);
	end

	cr_response_collector #(
		.NUM_CORES(NUM_CORES),
		.STRANDS_PER_CORE(STRANDS_PER_CORE)
	) collector_i (
		.clk(clk),
		.reset(reset),
		.read_pending(read_pending),
		.read_select(read_select),
		.read_values(read_values),
		.core_enables(core_enables),
		.read_valid(read_valid),
		.read_data(read_data),
		.strand_enable(strand_enable),
		.all_halted(all_halted)
	);

endmodule
